/* src/axi_pkg.sv */
package axi_pkg;

    typedef logic [31:0] axi_addr_t;  // Byte address.
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;   // Beats minus one.
    typedef logic [2:0]  axi_size_t;  // Log2 of the bytes per beat.
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    // Response codes.
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    localparam axi_burst_t BURST_INCR = 2'b01;
    localparam axi_size_t  SIZE_WORD  = 3'd2;  // Four bytes per beat.

endpackage

/* src/mem_pkg.sv */
package mem_pkg;

    import axi_pkg::*;

    // The SRAM holds 256 words, so the map covers 1 KiB from address zero.
    localparam int MEM_WORDS = 256;
    typedef logic [7:0] mem_index_t;

    localparam int FETCH_BEATS = 4;  // Words per cache line.

    localparam axi_id_t FETCH_ID = 4'd0;
    localparam axi_id_t LSU_ID   = 4'd1;

    // Which client owns the shared port.
    typedef enum logic [1:0] {
        GRANT_IDLE,
        GRANT_FETCH,
        GRANT_LSU
    } grant_t;

endpackage

/* src/axi_if.sv */
`timescale 1ns/1ps

interface axi_if import axi_pkg::*; ();

    logic       awvalid, awready;
    axi_addr_t  awaddr;
    axi_id_t    awid;
    axi_len_t   awlen;
    axi_size_t  awsize;
    axi_burst_t awburst;

    logic       wvalid, wready, wlast;
    axi_data_t  wdata;
    axi_strb_t  wstrb;

    logic       bvalid, bready;
    axi_resp_t  bresp;
    axi_id_t    bid;

    logic       arvalid, arready;
    axi_addr_t  araddr;
    axi_id_t    arid;
    axi_len_t   arlen;
    axi_size_t  arsize;
    axi_burst_t arburst;

    logic       rvalid, rready, rlast;
    axi_data_t  rdata;
    axi_resp_t  rresp;
    axi_id_t    rid;

    modport master (
        output awvalid, awaddr, awid, awlen, awsize, awburst,
        output wvalid, wdata, wstrb, wlast, bready,
        output arvalid, araddr, arid, arlen, arsize, arburst, rready,
        input  awready, wready, bvalid, bresp, bid,
        input  arready, rvalid, rdata, rresp, rlast, rid
    );

    modport slave (
        input  awvalid, awaddr, awid, awlen, awsize, awburst,
        input  wvalid, wdata, wstrb, wlast, bready,
        input  arvalid, araddr, arid, arlen, arsize, arburst, rready,
        output awready, wready, bvalid, bresp, bid,
        output arready, rvalid, rdata, rresp, rlast, rid
    );

endinterface

/* src/axi_arbiter.sv */
`timescale 1ns/1ps

module axi_arbiter import axi_pkg::*, mem_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic fetch_req,
    input  logic lsu_req,
    axi_if.slave  fetch_bus,
    axi_if.slave  lsu_bus,
    axi_if.master mem_bus
);

    grant_t grant;
    logic   fetch_on, lsu_on, done;

    assign fetch_on = (grant == GRANT_FETCH);
    assign lsu_on   = (grant == GRANT_LSU);

    // A grant closes only on a completed last read beat or write response.
    assign done = (mem_bus.rvalid && mem_bus.rready && mem_bus.rlast) ||
                  (mem_bus.bvalid && mem_bus.bready);

    always_ff @(posedge clock) begin
        if (reset) begin
            grant <= GRANT_IDLE;
        end else begin
            case (grant)
                GRANT_IDLE: begin
                    if (lsu_req)
                        grant <= GRANT_LSU;  // Load/store wins a tie.
                    else if (fetch_req)
                        grant <= GRANT_FETCH;
                end
                GRANT_FETCH: if (done) grant <= lsu_req ? GRANT_LSU : GRANT_IDLE;
                GRANT_LSU:   if (done) grant <= fetch_req ? GRANT_FETCH : GRANT_IDLE;
                default:     grant <= GRANT_IDLE;
            endcase
        end
    end

    // Requests towards the SRAM. Nothing reaches it while idle.
    assign mem_bus.awvalid = fetch_on ? fetch_bus.awvalid : lsu_on ? lsu_bus.awvalid : 1'b0;
    assign mem_bus.awaddr  = fetch_on ? fetch_bus.awaddr  : lsu_on ? lsu_bus.awaddr  : '0;
    assign mem_bus.awid    = fetch_on ? fetch_bus.awid    : lsu_on ? lsu_bus.awid    : '0;
    assign mem_bus.awlen   = fetch_on ? fetch_bus.awlen   : lsu_on ? lsu_bus.awlen   : '0;
    assign mem_bus.awsize  = fetch_on ? fetch_bus.awsize  : lsu_on ? lsu_bus.awsize  : '0;
    assign mem_bus.awburst = fetch_on ? fetch_bus.awburst : lsu_on ? lsu_bus.awburst : '0;
    assign mem_bus.wvalid  = fetch_on ? fetch_bus.wvalid  : lsu_on ? lsu_bus.wvalid  : 1'b0;
    assign mem_bus.wdata   = fetch_on ? fetch_bus.wdata   : lsu_on ? lsu_bus.wdata   : '0;
    assign mem_bus.wstrb   = fetch_on ? fetch_bus.wstrb   : lsu_on ? lsu_bus.wstrb   : '0;
    assign mem_bus.wlast   = fetch_on ? fetch_bus.wlast   : lsu_on ? lsu_bus.wlast   : 1'b0;
    assign mem_bus.bready  = fetch_on ? fetch_bus.bready  : lsu_on ? lsu_bus.bready  : 1'b0;
    assign mem_bus.arvalid = fetch_on ? fetch_bus.arvalid : lsu_on ? lsu_bus.arvalid : 1'b0;
    assign mem_bus.araddr  = fetch_on ? fetch_bus.araddr  : lsu_on ? lsu_bus.araddr  : '0;
    assign mem_bus.arid    = fetch_on ? fetch_bus.arid    : lsu_on ? lsu_bus.arid    : '0;
    assign mem_bus.arlen   = fetch_on ? fetch_bus.arlen   : lsu_on ? lsu_bus.arlen   : '0;
    assign mem_bus.arsize  = fetch_on ? fetch_bus.arsize  : lsu_on ? lsu_bus.arsize  : '0;
    assign mem_bus.arburst = fetch_on ? fetch_bus.arburst : lsu_on ? lsu_bus.arburst : '0;
    assign mem_bus.rready  = fetch_on ? fetch_bus.rready  : lsu_on ? lsu_bus.rready  : 1'b0;

    // Responses back to the fetch client.
    assign fetch_bus.awready = fetch_on && mem_bus.awready;
    assign fetch_bus.wready  = fetch_on && mem_bus.wready;
    assign fetch_bus.bvalid  = fetch_on && mem_bus.bvalid;
    assign fetch_bus.bresp   = fetch_on ? mem_bus.bresp : '0;
    assign fetch_bus.bid     = fetch_on ? mem_bus.bid   : '0;
    assign fetch_bus.arready = fetch_on && mem_bus.arready;
    assign fetch_bus.rvalid  = fetch_on && mem_bus.rvalid;
    assign fetch_bus.rdata   = fetch_on ? mem_bus.rdata : '0;
    assign fetch_bus.rresp   = fetch_on ? mem_bus.rresp : '0;
    assign fetch_bus.rlast   = fetch_on && mem_bus.rlast;
    assign fetch_bus.rid     = fetch_on ? mem_bus.rid   : '0;

    // Responses back to the load/store client.
    assign lsu_bus.awready = lsu_on && mem_bus.awready;
    assign lsu_bus.wready  = lsu_on && mem_bus.wready;
    assign lsu_bus.bvalid  = lsu_on && mem_bus.bvalid;
    assign lsu_bus.bresp   = lsu_on ? mem_bus.bresp : '0;
    assign lsu_bus.bid     = lsu_on ? mem_bus.bid   : '0;
    assign lsu_bus.arready = lsu_on && mem_bus.arready;
    assign lsu_bus.rvalid  = lsu_on && mem_bus.rvalid;
    assign lsu_bus.rdata   = lsu_on ? mem_bus.rdata : '0;
    assign lsu_bus.rresp   = lsu_on ? mem_bus.rresp : '0;
    assign lsu_bus.rlast   = lsu_on && mem_bus.rlast;
    assign lsu_bus.rid     = lsu_on ? mem_bus.rid   : '0;

endmodule

/* src/fetch_master.sv */
`timescale 1ns/1ps

module fetch_master import axi_pkg::*, mem_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      fetch_valid,
    input  axi_addr_t fetch_addr,
    output logic      fetch_ready,
    output logic      fetch_rvalid,
    output logic      fetch_rlast,
    output axi_data_t fetch_rdata,
    output logic      req,
    axi_if.master     bus
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA
    } fetch_state_t;

    fetch_state_t state;
    axi_addr_t    line_q;
    logic         r_fire;

    assign fetch_ready = (state == FETCH_IDLE);
    assign req         = (state != FETCH_IDLE);
    assign r_fire      = bus.rvalid && bus.rready;

    assign bus.arvalid = (state == FETCH_ADDR);
    assign bus.araddr  = line_q;
    assign bus.arid    = FETCH_ID;
    assign bus.arlen   = axi_len_t'(FETCH_BEATS - 1);
    assign bus.arsize  = SIZE_WORD;
    assign bus.arburst = BURST_INCR;
    assign bus.rready  = (state == FETCH_DATA);  // Never stalls the burst.

    // Instruction fetch never writes.
    assign bus.awvalid = 1'b0;
    assign bus.awaddr  = '0;
    assign bus.awid    = '0;
    assign bus.awlen   = '0;
    assign bus.awsize  = '0;
    assign bus.awburst = '0;
    assign bus.wvalid  = 1'b0;
    assign bus.wdata   = '0;
    assign bus.wstrb   = '0;
    assign bus.wlast   = 1'b0;
    assign bus.bready  = 1'b0;

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= FETCH_IDLE;
            fetch_rvalid <= 1'b0;
            fetch_rlast  <= 1'b0;
        end else begin
            fetch_rvalid <= r_fire;
            fetch_rlast  <= r_fire && bus.rlast;
            case (state)
                FETCH_IDLE: if (fetch_valid) state <= FETCH_ADDR;
                FETCH_ADDR: if (bus.arready) state <= FETCH_DATA;
                FETCH_DATA: if (r_fire && bus.rlast) state <= FETCH_IDLE;
                default:    state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_valid && fetch_ready)
            line_q <= fetch_addr & ~axi_addr_t'(FETCH_BEATS * 4 - 1);  // Line base.
        if (r_fire)
            fetch_rdata <= bus.rdata;
    end

endmodule

/* src/lsu_master.sv */
`timescale 1ns/1ps

module lsu_master import axi_pkg::*, mem_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      lsu_valid,
    input  logic      lsu_write,
    input  axi_addr_t lsu_addr,
    input  axi_data_t lsu_wdata,
    input  axi_strb_t lsu_wstrb,
    output logic      lsu_ready,
    output logic      lsu_done,
    output logic      lsu_error,
    output axi_data_t lsu_rdata,
    output logic      req,
    axi_if.master     bus
);

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_READ,
        LSU_WRITE
    } lsu_state_t;

    lsu_state_t state;
    logic       addr_pend, w_pend;  // Address and data beats still to be handed over.
    logic       accept, r_fire, b_fire;
    axi_addr_t  addr_q;
    axi_data_t  wdata_q;
    axi_strb_t  wstrb_q;

    assign lsu_ready = (state == LSU_IDLE);
    assign req       = (state != LSU_IDLE);
    assign accept    = lsu_valid && lsu_ready;
    assign r_fire    = bus.rvalid && bus.rready;
    assign b_fire    = bus.bvalid && bus.bready;

    assign bus.arvalid = (state == LSU_READ) && addr_pend;
    assign bus.araddr  = addr_q;
    assign bus.arid    = LSU_ID;
    assign bus.arlen   = '0;
    assign bus.arsize  = SIZE_WORD;
    assign bus.arburst = BURST_INCR;
    assign bus.rready  = (state == LSU_READ);

    assign bus.awvalid = (state == LSU_WRITE) && addr_pend;
    assign bus.awaddr  = addr_q;
    assign bus.awid    = LSU_ID;
    assign bus.awlen   = '0;
    assign bus.awsize  = SIZE_WORD;
    assign bus.awburst = BURST_INCR;
    assign bus.wvalid  = (state == LSU_WRITE) && w_pend;
    assign bus.wdata   = wdata_q;
    assign bus.wstrb   = wstrb_q;
    assign bus.wlast   = 1'b1;
    assign bus.bready  = (state == LSU_WRITE);

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= LSU_IDLE;
            addr_pend <= 1'b0;
            w_pend    <= 1'b0;
            lsu_done  <= 1'b0;
        end else begin
            lsu_done <= r_fire || b_fire;
            case (state)
                LSU_IDLE: begin
                    if (lsu_valid) begin
                        state     <= lsu_write ? LSU_WRITE : LSU_READ;
                        addr_pend <= 1'b1;
                        w_pend    <= lsu_write;
                    end
                end
                LSU_READ: begin
                    if (bus.arready) addr_pend <= 1'b0;
                    if (r_fire) state <= LSU_IDLE;
                end
                LSU_WRITE: begin
                    if (bus.awready) addr_pend <= 1'b0;  // aw and w retire on their own.
                    if (bus.wready) w_pend <= 1'b0;
                    if (b_fire) state <= LSU_IDLE;
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= lsu_addr;
            wdata_q <= lsu_wdata;
            wstrb_q <= lsu_wstrb;
        end
        if (r_fire || b_fire) begin
            lsu_rdata <= r_fire ? bus.rdata : '0;
            lsu_error <= (r_fire ? bus.rresp : bus.bresp) != RESP_OKAY;
        end
    end

endmodule

/* src/axi_sram.sv */
`timescale 1ns/1ps

module axi_sram import axi_pkg::*, mem_pkg::*; (
    input  logic clock,
    input  logic reset,
    axi_if.slave bus
);

    axi_data_t  mem [MEM_WORDS];
    logic       ar_fire, r_fire, beat_load;
    axi_addr_t  beat_addr, rd_next;
    axi_len_t   rd_left;  // Beats after the one on the bus.
    logic       aw_got, w_got, aw_fire, w_fire, wr_go;
    axi_addr_t  aw_addr_q, wr_addr;
    axi_id_t    aw_id_q;
    axi_data_t  w_data_q, wr_data;
    axi_strb_t  w_strb_q, wr_strb;

    function automatic logic in_range(axi_addr_t a);
        return (a >> 2) < axi_addr_t'(MEM_WORDS);
    endfunction

    function automatic mem_index_t word_index(axi_addr_t a);
        return mem_index_t'(a >> 2);
    endfunction

    assign ar_fire     = bus.arvalid && bus.arready;
    assign r_fire      = bus.rvalid && bus.rready;
    assign beat_load   = ar_fire || (r_fire && !bus.rlast);
    assign beat_addr   = ar_fire ? bus.araddr : rd_next;
    assign bus.arready = !bus.rvalid;
    assign bus.rlast   = bus.rvalid && (rd_left == '0);

    always_ff @(posedge clock) begin
        if (reset)
            bus.rvalid <= 1'b0;
        else if (beat_load)
            bus.rvalid <= 1'b1;
        else if (r_fire)
            bus.rvalid <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (beat_load) begin
            bus.rdata <= in_range(beat_addr) ? mem[word_index(beat_addr)] : '0;
            bus.rresp <= in_range(beat_addr) ? RESP_OKAY : RESP_DECERR;
            rd_next   <= beat_addr + 32'd4;
            rd_left   <= ar_fire ? bus.arlen : rd_left - 1'b1;
        end
        if (ar_fire)
            bus.rid <= bus.arid;
    end

    // The write address and data may arrive in either order.
    assign bus.awready = !aw_got && !bus.bvalid;
    assign bus.wready  = !w_got && !bus.bvalid;
    assign aw_fire     = bus.awvalid && bus.awready;
    assign w_fire      = bus.wvalid && bus.wready;
    assign wr_go       = (aw_got || aw_fire) && (w_got || w_fire);
    assign wr_addr     = aw_got ? aw_addr_q : bus.awaddr;
    assign wr_data     = w_got ? w_data_q : bus.wdata;
    assign wr_strb     = w_got ? w_strb_q : bus.wstrb;

    always_ff @(posedge clock) begin
        if (reset) begin
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            bus.bvalid <= 1'b0;
        end else if (wr_go) begin
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            bus.bvalid <= 1'b1;
        end else begin
            if (aw_fire) aw_got <= 1'b1;
            if (w_fire) w_got <= 1'b1;
            if (bus.bvalid && bus.bready) bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire) begin
            aw_addr_q <= bus.awaddr;
            aw_id_q   <= bus.awid;
        end
        if (w_fire) begin
            w_data_q <= bus.wdata;
            w_strb_q <= bus.wstrb;
        end
        if (wr_go) begin
            bus.bresp <= in_range(wr_addr) ? RESP_OKAY : RESP_DECERR;
            bus.bid   <= aw_got ? aw_id_q : bus.awid;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= '0;
        end else if (wr_go && in_range(wr_addr)) begin
            for (int b = 0; b < $bits(axi_strb_t); b++)
                if (wr_strb[b])
                    mem[word_index(wr_addr)][8*b +: 8] <= wr_data[8*b +: 8];
        end
    end

endmodule

/* src/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem import axi_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      fetch_valid,
    input  axi_addr_t fetch_addr,
    output logic      fetch_ready,
    output logic      fetch_rvalid,
    output axi_data_t fetch_rdata,
    output logic      fetch_rlast,
    input  logic      lsu_valid,
    input  logic      lsu_write,
    input  axi_addr_t lsu_addr,
    input  axi_data_t lsu_wdata,
    input  axi_strb_t lsu_wstrb,
    output logic      lsu_ready,
    output logic      lsu_done,
    output axi_data_t lsu_rdata,
    output logic      lsu_error
);

    logic fetch_req, lsu_req;

    axi_if fetch_bus ();
    axi_if lsu_bus ();
    axi_if mem_bus ();

    fetch_master i_fetch_master (
        .clock, .reset, .fetch_valid, .fetch_addr, .fetch_ready,
        .fetch_rvalid, .fetch_rlast, .fetch_rdata,
        .req (fetch_req),
        .bus (fetch_bus)
    );

    lsu_master i_lsu_master (
        .clock, .reset, .lsu_valid, .lsu_write, .lsu_addr, .lsu_wdata, .lsu_wstrb,
        .lsu_ready, .lsu_done, .lsu_error, .lsu_rdata,
        .req (lsu_req),
        .bus (lsu_bus)
    );

    axi_arbiter i_axi_arbiter (
        .clock, .reset, .fetch_req, .lsu_req,
        .fetch_bus (fetch_bus),
        .lsu_bus   (lsu_bus),
        .mem_bus   (mem_bus)
    );

    axi_sram i_axi_sram (
        .clock, .reset,
        .bus (mem_bus)
    );

endmodule

/* sim/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem import axi_pkg::*, mem_pkg::*; ();

    localparam int N_PAIRS     = 40;
    localparam int N_PARTIAL   = 30;
    localparam int N_FETCH     = 30;
    localparam int N_MIX       = 50;
    localparam int N_OOB       = 4;
    localparam int TOTAL_REQ   = 2*N_PAIRS + 2*N_PARTIAL + N_FETCH + 2 + 2*N_MIX + 4*N_OOB;
    localparam int CYCLE_LIMIT = 40 * TOTAL_REQ + 500;

    typedef struct packed {
        logic      write;
        axi_addr_t addr;
        axi_data_t data;
        axi_strb_t strb;
    } lsu_op_t;

    logic      clock, reset;
    logic      fetch_valid, fetch_ready, fetch_rvalid, fetch_rlast;
    axi_addr_t fetch_addr;
    axi_data_t fetch_rdata;
    logic      lsu_valid, lsu_write, lsu_ready, lsu_done, lsu_error;
    axi_addr_t lsu_addr;
    axi_data_t lsu_wdata, lsu_rdata;
    axi_strb_t lsu_wstrb;

    axi_data_t   model [MEM_WORDS];  // Reference copy of the SRAM.
    lsu_op_t     lsu_q [$];
    axi_addr_t   fetch_q [$];        // Line bases of fetches in flight.
    int          fetch_beat = 0;
    logic [31:0] rng;
    int          errors = 0, checks = 0, tests = 0, failed_tests = 0;
    int          test_start_errors = 0, cycles = 0;

    mem_subsystem i_mem_subsystem (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic axi_addr_t map_addr(logic [31:0] r, logic beyond);
        axi_addr_t a;
        a = {22'h0, r[9:2], 2'b00};
        if (beyond)
            a[31:10] = r[31:10] | 22'h1;  // Anything at or above 1 KiB.
        return a;
    endfunction

    function automatic axi_addr_t pick_addr();
        logic [31:0] r;
        r = rand_word();
        return map_addr(r, rand_word() < 32'h1000_0000);
    endfunction

    function automatic logic in_map(axi_addr_t a);
        return a[31:10] == '0;
    endfunction

    function automatic axi_data_t model_word(axi_addr_t a);
        return in_map(a) ? model[a[9:2]] : '0;
    endfunction

    function automatic axi_data_t merge_bytes(axi_data_t old, axi_data_t data, axi_strb_t strb);
        axi_data_t res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (strb[b])
                res[8*b +: 8] = data[8*b +: 8];
        return res;
    endfunction

    task automatic check_data(string name, axi_data_t got, axi_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic report_failure(string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // Each response pulse is matched against the oldest request of its client.
    always @(negedge clock) begin : watch_responses
        lsu_op_t   op;
        axi_addr_t exp_addr;
        if (!reset && fetch_rvalid) begin
            if (fetch_q.size() == 0) begin
                report_failure("a fetch word arrived with no fetch in flight");
            end else begin
                exp_addr = fetch_q[0] + axi_addr_t'(4 * fetch_beat);
                check_data("fetch_rdata", fetch_rdata, model_word(exp_addr));
                check_flag("fetch_rlast", fetch_rlast, fetch_beat == FETCH_BEATS - 1);
                fetch_beat++;
                if (fetch_beat == FETCH_BEATS) begin
                    fetch_beat = 0;
                    void'(fetch_q.pop_front());
                end
            end
        end
        if (!reset && lsu_done) begin
            if (lsu_q.size() == 0) begin
                report_failure("lsu_done pulsed with no load or store in flight");
            end else begin
                op = lsu_q.pop_front();
                check_flag("lsu_error", lsu_error, !in_map(op.addr));
                if (op.write) begin
                    check_data("lsu_rdata", lsu_rdata, '0);
                    if (in_map(op.addr))
                        model[op.addr[9:2]] = merge_bytes(model[op.addr[9:2]], op.data, op.strb);
                end else begin
                    check_data("lsu_rdata", lsu_rdata, model_word(op.addr));
                end
            end
        end
    end

    task automatic drive_lsu(logic write, axi_addr_t addr, axi_data_t data, axi_strb_t strb);
        lsu_op_t op;
        op.write  = write;
        op.addr   = addr;
        op.data   = data;
        op.strb   = strb;
        lsu_valid = 1'b1;
        lsu_write = write;
        lsu_addr  = addr;
        lsu_wdata = data;
        lsu_wstrb = strb;
        lsu_q.push_back(op);
    endtask

    task automatic send_lsu(logic write, axi_addr_t addr, axi_data_t data, axi_strb_t strb);
        @(negedge clock);
        while (!lsu_ready) @(negedge clock);
        drive_lsu(write, addr, data, strb);
        @(negedge clock);
        lsu_valid = 1'b0;
    endtask

    task automatic send_fetch(axi_addr_t addr);
        @(negedge clock);
        while (!fetch_ready) @(negedge clock);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        fetch_q.push_back({addr[31:4], 4'h0});
        @(negedge clock);
        fetch_valid = 1'b0;
    endtask

    // Both requests are accepted on the same clock edge.
    task automatic send_both(axi_addr_t f_addr, axi_addr_t l_addr);
        @(negedge clock);
        while (!(fetch_ready && lsu_ready)) @(negedge clock);
        fetch_valid = 1'b1;
        fetch_addr  = f_addr;
        fetch_q.push_back({f_addr[31:4], 4'h0});
        drive_lsu(1'b0, l_addr, '0, '0);
        @(negedge clock);
        fetch_valid = 1'b0;
        lsu_valid   = 1'b0;
    endtask

    task automatic mix_lsu_traffic();
        logic [31:0] r;
        for (int i = 0; i < N_MIX; i++) begin
            r = rand_word();
            repeat (r[9:8]) @(negedge clock);
            send_lsu(r[0], pick_addr(), rand_word(), r[7:4]);
        end
    endtask

    task automatic mix_fetch_traffic();
        logic [31:0] r;
        for (int i = 0; i < N_MIX; i++) begin
            r = rand_word();
            repeat (r[2:0]) @(negedge clock);
            send_fetch(pick_addr());
        end
    endtask

    task automatic wait_idle();
        while (lsu_q.size() != 0 || fetch_q.size() != 0) @(negedge clock);
    endtask

    task automatic end_test(string name);
        wait_idle();
        tests++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: FAIL with %0d errors", tests, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        axi_addr_t   a;
        axi_strb_t   s;
        logic [31:0] r;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        lsu_valid   = 1'b0;
        lsu_write   = 1'b0;
        lsu_addr    = '0;
        lsu_wdata   = '0;
        lsu_wstrb   = '0;
        rng         = 32'd11;
        for (int i = 0; i < MEM_WORDS; i++)
            model[i] = '0;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        repeat (20) begin
            @(negedge clock);
            check_flag("fetch_rvalid", fetch_rvalid, 1'b0);
            check_flag("lsu_done", lsu_done, 1'b0);
            check_flag("fetch_ready", fetch_ready, 1'b1);
            check_flag("lsu_ready", lsu_ready, 1'b1);
        end
        end_test("idle after reset");

        for (int i = 0; i < N_PAIRS; i++) begin
            a = pick_addr();
            send_lsu(1'b1, a, rand_word(), 4'hf);
            send_lsu(1'b0, a, '0, '0);
        end
        end_test("full word store and load");

        for (int i = 0; i < N_PARTIAL; i++) begin
            a = pick_addr();
            r = rand_word();
            s = (r[3:0] == 4'hf) ? 4'h5 : r[3:0];
            send_lsu(1'b1, a, rand_word(), s);
            send_lsu(1'b0, a, '0, '0);
        end
        end_test("partial strobe store");

        for (int i = 0; i < N_FETCH; i++) begin
            a = pick_addr();
            r = rand_word();
            a[3:0] = r[3:0];  // Any byte inside the line.
            send_fetch(a);
        end
        end_test("line fetch");

        send_both(pick_addr(), pick_addr());
        while (!lsu_done && !fetch_rvalid) @(negedge clock);
        check_flag("lsu_done", lsu_done, 1'b1);
        check_flag("fetch_rvalid", fetch_rvalid, 1'b0);
        wait_idle();
        fork
            mix_lsu_traffic();
            mix_fetch_traffic();
        join
        end_test("contention between clients");

        for (int i = 0; i < N_OOB; i++) begin
            a = map_addr(rand_word(), 1'b1);
            send_lsu(1'b1, a, rand_word(), 4'hf);
            send_lsu(1'b0, a, '0, '0);
            send_fetch(a);
            send_lsu(1'b0, {22'h0, a[9:0]}, '0, '0);  // Same low bits inside the map.
        end
        end_test("decode error");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* sim.f */
src/axi_pkg.sv
src/mem_pkg.sv
src/axi_if.sv
src/axi_arbiter.sv
src/fetch_master.sv
src/lsu_master.sv
src/axi_sram.sv
src/mem_subsystem.sv
sim/tb_mem_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed!

SOURCES := $(wildcard src/*.sv) $(wildcard sim/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
